/* verilog/loader_config.svh */
`ifndef LOADER_CONFIG_SVH
`define LOADER_CONFIG_SVH

// ************************************************
// serial timing.
// ************************************************

// clock cycles per serial bit.
`define LOADER_CLKS_PER_BIT 8

// quiet cycles on the line before the image is started.
`define LOADER_HOLD_CYCLES 64

// reset cause word after a loader reset.
`define LOADER_CAUSE_LOADER 32'h1

`endif

/* verilog/loader_pkg.sv */
package loader_pkg;

	// ************************************************
	// bus types.
	// ************************************************

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [31:0] adr;
		logic [31:0] dat;
		logic [3:0]  sel;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

	// one cycle strobe per received byte.
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} rx_byte_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ARMED,
		ST_RESET,
		ST_LOADING,
		ST_HOLD
	} loader_state_t;

	// arming sequence is '-', any number of '_', then 'p'.
	localparam logic [7:0] CMD_ARM = 8'h2d;
	localparam logic [7:0] CMD_PAD = 8'h5f;
	localparam logic [7:0] CMD_GO  = 8'h70;

endpackage

/* verilog/uart_rx.sv */
`timescale 1ns/1ps

`include "loader_config.svh"

module uart_rx
	import loader_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     uart_rx_i,
	output rx_byte_t rx_byte_o
);

	localparam int CLKS = `LOADER_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CLKS + 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t rx_state;
	logic [1:0] sync_q;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift_q;
	logic valid_q;
	logic rx_bit;
	logic half_bit;
	logic full_bit;

	assign rx_bit = sync_q[1];
	assign half_bit = (clk_cnt == CNT_W'(CLKS / 2 - 1));
	assign full_bit = (clk_cnt == CNT_W'(CLKS - 1));

	// two flop synchronizer, line idles high.
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			sync_q <= 2'b11;
		else
			sync_q <= {sync_q[0], uart_rx_i};
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			rx_state <= RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= 1'b0;
			clk_cnt <= clk_cnt + 1'b1;
			case (rx_state)
				RX_IDLE:
				begin
					clk_cnt <= '0;
					if (!rx_bit)
						rx_state <= RX_START;
				end
				RX_START:
				begin
					// confirm the start bit at mid-bit.
					if (half_bit)
					begin
						clk_cnt <= '0;
						bit_idx <= '0;
						rx_state <= rx_bit ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA:
				begin
					if (full_bit)
					begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							rx_state <= RX_STOP;
					end
				end
				RX_STOP:
				begin
					// a low stop bit drops the frame.
					if (full_bit)
					begin
						valid_q <= rx_bit;
						rx_state <= RX_IDLE;
					end
				end
				default: rx_state <= RX_IDLE;
			endcase
		end
	end

	// data bits arrive lsb first.
	always_ff @(posedge clk)
	begin
		if (rx_state == RX_DATA && full_bit)
			shift_q <= {rx_bit, shift_q[7:1]};
	end

	assign rx_byte_o.valid = valid_q;
	assign rx_byte_o.data = shift_q;

	a_strobe_single: assert property (@(posedge clk) disable iff (!rst)
		rx_byte_o.valid |=> !rx_byte_o.valid);

endmodule

/* verilog/loader_ctrl.sv */
`timescale 1ns/1ps

`include "loader_config.svh"

module loader_ctrl
	import loader_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  rx_byte_t   rx_byte_i,
	output logic       cpu_rst_o,
	output logic       cause_loader_o,
	output logic [2:0] led_o
);

	localparam int HOLD = `LOADER_HOLD_CYCLES;
	localparam int HOLD_W = $clog2(HOLD + 1);

	loader_state_t state;
	loader_state_t next_state;
	logic [HOLD_W-1:0] hold_cnt;
	logic go_hit;
	logic hold_done;

	assign go_hit = (state == ST_ARMED) && rx_byte_i.valid
		&& (rx_byte_i.data == CMD_GO);

	// hold_cnt is 0 in the cycle after a byte, so the pulse lands
	// hold cycles plus one after the last strobe.
	assign hold_done = (state == ST_HOLD) && !rx_byte_i.valid
		&& (hold_cnt == HOLD_W'(HOLD - 1));

	// ************************************************
	// state machine.
	// ************************************************

	always_comb
	begin
		next_state = state;
		case (state)
			ST_IDLE:
			begin
				if (rx_byte_i.valid && rx_byte_i.data == CMD_ARM)
					next_state = ST_ARMED;
			end
			ST_ARMED:
			begin
				if (go_hit)
					next_state = ST_RESET;
				else if (rx_byte_i.valid && rx_byte_i.data != CMD_PAD)
					next_state = ST_IDLE;
			end
			ST_RESET: next_state = ST_LOADING;
			ST_LOADING:
			begin
				// first image byte.
				if (rx_byte_i.valid)
					next_state = ST_HOLD;
			end
			ST_HOLD:
			begin
				if (hold_done)
					next_state = ST_IDLE;
			end
			default: next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	// quiet time counter, restarted by every byte.
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			hold_cnt <= '0;
		else if (state == ST_HOLD && !rx_byte_i.valid)
			hold_cnt <= hold_cnt + 1'b1;
		else
			hold_cnt <= '0;
	end

	// ************************************************
	// reset pulse and reset cause.
	// ************************************************

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			cpu_rst_o <= 1'b1;
		else
			cpu_rst_o <= !(go_hit || hold_done);
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			cause_loader_o <= 1'b0;
		else if (next_state == ST_RESET)
			cause_loader_o <= 1'b1;
		else if (next_state == ST_IDLE)
			cause_loader_o <= 1'b0;
	end

	assign led_o[0] = (state == ST_IDLE);
	assign led_o[1] = (state == ST_ARMED);
	assign led_o[2] = (state == ST_LOADING);

	a_rst_pulse: assert property (@(posedge clk) disable iff (!rst)
		!cpu_rst_o |=> cpu_rst_o);

endmodule

/* verilog/loader_wb_slave.sv */
`timescale 1ns/1ps

`include "loader_config.svh"

module loader_wb_slave
	import loader_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  wb_req_t wb_req_i,
	input  logic    cause_loader_i,
	output wb_rsp_t wb_rsp_o
);

	logic stb_q;

	// ************************************************
	// registered acknowledge.
	// ************************************************

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			stb_q <= 1'b0;
		else
			stb_q <= wb_req_i.stb;
	end

	// an aborted cycle drops the pending ack.
	assign wb_rsp_o.ack = stb_q & wb_req_i.cyc;

	// single register, so the address is not decoded.
	// writes get an ack and change nothing.
	assign wb_rsp_o.dat = cause_loader_i ? `LOADER_CAUSE_LOADER : 32'h0;

	a_ack_needs_cyc: assert property (@(posedge clk) disable iff (!rst)
		!wb_req_i.cyc |-> !wb_rsp_o.ack);

endmodule

/* verilog/loader_top.sv */
`timescale 1ns/1ps

module loader_top
	import loader_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       uart_rx_i,
	input  wb_req_t    wb_req_i,
	output wb_rsp_t    wb_rsp_o,
	output logic       cpu_rst_o,
	output logic [2:0] led_o
);

	rx_byte_t rx_byte;
	logic cause_loader;

	// ************************************************
	// serial receiver.
	// ************************************************

	uart_rx u_uart_rx (
		.clk       (clk),
		.rst       (rst),
		.uart_rx_i (uart_rx_i),
		.rx_byte_o (rx_byte)
	);

	// ************************************************
	// loader control and bus slave.
	// ************************************************

	loader_ctrl u_loader_ctrl (
		.clk            (clk),
		.rst            (rst),
		.rx_byte_i      (rx_byte),
		.cpu_rst_o      (cpu_rst_o),
		.cause_loader_o (cause_loader),
		.led_o          (led_o)
	);

	loader_wb_slave u_loader_wb_slave (
		.clk            (clk),
		.rst            (rst),
		.wb_req_i       (wb_req_i),
		.cause_loader_i (cause_loader),
		.wb_rsp_o       (wb_rsp_o)
	);

endmodule

/* tests/loader_tb.sv */
`timescale 1ns/1ps

`include "loader_config.svh"

module loader_tb
	import loader_pkg::*;
();

	localparam int CLKS = `LOADER_CLKS_PER_BIT;
	localparam int HOLD = `LOADER_HOLD_CYCLES;
	localparam int PAT_DEPTH = 256;

	// pattern opcodes, upper nibble of each word.
	localparam logic [3:0] OP_END = 4'h0;
	localparam logic [3:0] OP_SEND = 4'h1;
	localparam logic [3:0] OP_IDLE = 4'h2;
	localparam logic [3:0] OP_LED = 4'h3;
	localparam logic [3:0] OP_PULSES = 4'h4;
	localparam logic [3:0] OP_READ = 4'h5;
	localparam logic [3:0] OP_WRITE = 4'h6;

	logic clk;
	logic rst;
	logic uart_rx;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic cpu_rst;
	logic [2:0] led;

	logic [15:0] patterns [PAT_DEPTH];
	int pat_count;
	int pat_idx;
	int pulse_count = 0;
	int watchdog_cycles;
	integer seed = 32'had68_120d;

	loader_top uut (
		.clk       (clk),
		.rst       (rst),
		.uart_rx_i (uart_rx),
		.wb_req_i  (wb_req),
		.wb_rsp_o  (wb_rsp),
		.cpu_rst_o (cpu_rst),
		.led_o     (led)
	);

	// ************************************************
	// clock and reset pulse monitor.
	// ************************************************

	initial
		clk = 1'b0;

	always #2 clk = ~clk;

	// every falling edge of the processor reset is one pulse.
	always @(negedge cpu_rst)
	begin
		if (rst === 1'b1)
			pulse_count = pulse_count + 1;
	end

	// ************************************************
	// checks and stimulus tasks.
	// ************************************************

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("ERR t=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) @(posedge clk);
	endtask

	// 8N1 frame after a random quiet gap of whole bit times.
	task automatic send_byte(input logic [7:0] data);
		int gap;
		int i;
		logic [9:0] frame;
		gap = ({$random(seed)} % 8) * CLKS;
		frame = {1'b1, data, 1'b0};
		repeat (gap) @(posedge clk);
		for (i = 0; i < 10; i++)
		begin
			@(posedge clk);
			uart_rx <= frame[i];
			repeat (CLKS - 1) @(posedge clk);
		end
	endtask

	// single classic cycle, stb for one cycle, ack expected one cycle later.
	task automatic bus_cycle(input logic write, input logic [31:0] wdata,
		input logic [31:0] rdata);
		@(posedge clk);
		wb_req.cyc <= 1'b1;
		wb_req.stb <= 1'b1;
		wb_req.we <= write;
		wb_req.adr <= 32'h0;
		wb_req.dat <= wdata;
		wb_req.sel <= 4'hf;
		@(negedge clk);
		check_value("wb_rsp_o.ack", 32'h0, wb_rsp.ack);
		@(posedge clk);
		wb_req.stb <= 1'b0;
		@(negedge clk);
		check_value("wb_rsp_o.ack", 32'h1, wb_rsp.ack);
		if (!write)
			check_value("wb_rsp_o.dat", rdata, wb_rsp.dat);
		@(posedge clk);
		wb_req.cyc <= 1'b0;
		wb_req.we <= 1'b0;
		@(negedge clk);
		check_value("wb_rsp_o.ack", 32'h0, wb_rsp.ack);
	endtask

	task automatic run_pattern(input int index, input logic [15:0] word);
		logic [3:0] op;
		logic [11:0] arg;
		op = word[15:12];
		arg = word[11:0];
		case (op)
			OP_SEND: send_byte(arg[7:0]);
			OP_IDLE: idle_cycles(arg);
			OP_LED:
			begin
				@(negedge clk);
				check_value("led_o", arg, led);
			end
			OP_PULSES:
			begin
				// pulses are one cycle long, so the line is high here.
				@(negedge clk);
				check_value("reset pulse count", arg, pulse_count);
				check_value("cpu_rst_o", 32'h1, cpu_rst);
			end
			OP_READ: bus_cycle(1'b0, 32'h0, arg);
			OP_WRITE: bus_cycle(1'b1, arg, 32'h0);
			default:
			begin
				$display("pattern %0d holds the unknown opcode %0h", index, op);
				$display("Checks failed");
				$fatal(1);
			end
		endcase
	endtask

	// ************************************************
	// main sequence.
	// ************************************************

	initial
	begin
		rst = 1'b0;
		uart_rx = 1'b1;
		wb_req = '0;
		$readmemh("tests/loader_patterns.txt", patterns);
		pat_count = 0;
		while (pat_count < PAT_DEPTH && !$isunknown(patterns[pat_count])
			&& patterns[pat_count][15:12] != OP_END)
			pat_count = pat_count + 1;
		if (pat_count == 0)
		begin
			$display("the pattern file holds no commands");
			$display("Checks failed");
			$fatal(1);
		end
		repeat (2) @(posedge clk);
		rst <= 1'b1;
		@(posedge clk);
		for (pat_idx = 0; pat_idx < pat_count; pat_idx++)
			run_pattern(pat_idx, patterns[pat_idx]);
		idle_cycles(4);
		$display("All checks passed");
		$finish;
	end

	// each command gets 20 bit times, plus room for the hold time.
	initial
	begin
		@(posedge rst);
		watchdog_cycles = pat_count * 20 * CLKS + HOLD * 4;
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout, the patterns did not finish within %0d clock cycles",
			watchdog_cycles);
		$display("Checks failed");
		$fatal(1);
	end

endmodule

/* loader_top.f */
+incdir+verilog
verilog/loader_pkg.sv
verilog/uart_rx.sv
verilog/loader_ctrl.sv
verilog/loader_wb_slave.sv
verilog/loader_top.sv
tests/loader_tb.sv

/* tests/loader_patterns.txt */
// one command per line, a 16 bit hex word.
// bits 15:12 opcode: 1 send byte, 2 idle cycles, 3 expect led_o, 4 expect reset pulses,
// 5 bus read with expected data, 6 bus write data, 0 end. bits 11:0 operand.

// ************************************************
// after reset.
// ************************************************
3001
4000
5000

// ************************************************
// rejected arming.
// ************************************************
// '-' then 'x'.
102d
2004
3002
1078
2004
3001
4000
// 'p' alone in idle.
1070
2004
3001
4000
// '-', '_' then 'x'.
102d
105f
2004
3002
1078
2004
3001
4000

// ************************************************
// arming with two pad bytes.
// ************************************************
102d
105f
105f
2004
3002
1070
2004
4001
3004
5001
// write during loading leaves the cause.
6abc
5001
3004

// ************************************************
// loading and final reset.
// ************************************************
// first image byte, then checks well inside the hold time.
1041
2020
3000
4001
5001
6055
5001
// quiet line, second pulse.
2030
4002
3001
5000

// ************************************************
// arming with no pad byte.
// ************************************************
102d
1070
2004
4003
3004
5001
1042
2050
4004
3001
5000
0000
